//--- logic/cc_pkg.sv
package cc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  strb_t;
  // Bit 0 retired issue, bit 1 load writeback, bit 2 offload writeback
  typedef logic [2:0]  core_events_t;

  typedef enum logic [1:0] {
    MUL   = 2'd0,
    MULHU = 2'd1,
    DIVU  = 2'd2,
    REMU  = 2'd3
  } acc_op_e;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    WAIT_LOAD
  } core_state_e;

  localparam word_t       boot_addr   = 32'h0000_1000;
  localparam int unsigned mul_latency = 2;

  // Major opcodes of the subset
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_sub    = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;
  localparam logic [2:0] funct3_add    = 3'b000;
  localparam logic [2:0] funct3_word   = 3'b010;

  // Flattened payload widths for the cut registers
  localparam int unsigned offload_req_w =
    $bits(acc_op_e) + 2 * $bits(word_t) + $bits(reg_idx_t);
  localparam int unsigned offload_rsp_w = $bits(word_t) + $bits(reg_idx_t);
  localparam int unsigned mem_req_w     = 2 * $bits(word_t) + 1 + $bits(strb_t);

endpackage

//--- logic/core_complex.sv
`timescale 1ns/1ps

module core_complex #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1,
  parameter bit RegisterMemReq      = 1'b0,
  parameter bit RegisterMemResp     = 1'b0
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Instruction port
  output cc_pkg::word_t        inst_addr_o,
  input  cc_pkg::word_t        inst_data_i,
  output logic                 inst_valid_o,
  input  logic                 inst_ready_i,
  // Memory port
  output cc_pkg::word_t        data_qaddr_o,
  output logic                 data_qwrite_o,
  output cc_pkg::word_t        data_qdata_o,
  output cc_pkg::strb_t        data_qstrb_o,
  output logic                 data_qvalid_o,
  input  logic                 data_qready_i,
  input  cc_pkg::word_t        data_pdata_i,
  input  logic                 data_pvalid_i,
  output logic                 data_pready_o,
  output cc_pkg::core_events_t core_events_o
);

  import cc_pkg::*;

  offload_req_if acc_req_d ();
  offload_req_if acc_req_q ();
  offload_rsp_if acc_rsp_d ();
  offload_rsp_if acc_rsp_q ();

  logic [offload_req_w-1:0] acc_req_d_data, acc_req_q_data;
  logic [offload_rsp_w-1:0] acc_rsp_d_data, acc_rsp_q_data;

  // Core side of the memory cuts
  word_t mem_qaddr, mem_qdata, mem_pdata;
  strb_t mem_qstrb;
  logic  mem_qwrite, mem_qvalid, mem_qready, mem_pvalid, mem_pready;

  rv32_int_core i_core (
    .clk_i         ( clk_i            ),
    .rst_i         ( rst_i            ),
    .inst_addr_o   ( inst_addr_o      ),
    .inst_data_i   ( inst_data_i      ),
    .inst_valid_o  ( inst_valid_o     ),
    .inst_ready_i  ( inst_ready_i     ),
    .acc_req       ( acc_req_d.issuer ),
    .acc_rsp       ( acc_rsp_q.server ),
    .data_qaddr_o  ( mem_qaddr        ),
    .data_qwrite_o ( mem_qwrite       ),
    .data_qdata_o  ( mem_qdata        ),
    .data_qstrb_o  ( mem_qstrb        ),
    .data_qvalid_o ( mem_qvalid       ),
    .data_qready_i ( mem_qready       ),
    .data_pdata_i  ( mem_pdata        ),
    .data_pvalid_i ( mem_pvalid       ),
    .data_pready_o ( mem_pready       ),
    .core_events_o ( core_events_o    )
  );

  // Offload request cut
  assign acc_req_d_data = {acc_req_d.op, acc_req_d.arga, acc_req_d.argb, acc_req_d.id};

  spill_register #(
    .Width  ( offload_req_w       ),
    .Bypass ( !RegisterOffloadReq )
  ) i_spill_register_acc_req (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( acc_req_d.valid ),
    .ready_o ( acc_req_d.ready ),
    .data_i  ( acc_req_d_data  ),
    .valid_o ( acc_req_q.valid ),
    .ready_i ( acc_req_q.ready ),
    .data_o  ( acc_req_q_data  )
  );

  assign acc_req_q.op = acc_op_e'(acc_req_q_data[offload_req_w-1 -: $bits(acc_op_e)]);
  assign {acc_req_q.arga, acc_req_q.argb, acc_req_q.id} =
    acc_req_q_data[offload_req_w-$bits(acc_op_e)-1:0];

  shared_muldiv i_shared_muldiv (
    .clk_i ( clk_i            ),
    .rst_i ( rst_i            ),
    .req   ( acc_req_q.server ),
    .rsp   ( acc_rsp_d.issuer )
  );

  // Offload response cut
  assign acc_rsp_d_data = {acc_rsp_d.data, acc_rsp_d.id};

  spill_register #(
    .Width  ( offload_rsp_w        ),
    .Bypass ( !RegisterOffloadResp )
  ) i_spill_register_acc_rsp (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( acc_rsp_d.valid ),
    .ready_o ( acc_rsp_d.ready ),
    .data_i  ( acc_rsp_d_data  ),
    .valid_o ( acc_rsp_q.valid ),
    .ready_i ( acc_rsp_q.ready ),
    .data_o  ( acc_rsp_q_data  )
  );

  assign {acc_rsp_q.data, acc_rsp_q.id} = acc_rsp_q_data;

  // Memory request cut
  spill_register #(
    .Width  ( mem_req_w       ),
    .Bypass ( !RegisterMemReq )
  ) i_spill_register_mem_req (
    .clk_i   ( clk_i                                                      ),
    .rst_i   ( rst_i                                                      ),
    .valid_i ( mem_qvalid                                                 ),
    .ready_o ( mem_qready                                                 ),
    .data_i  ( {mem_qaddr, mem_qwrite, mem_qdata, mem_qstrb}              ),
    .valid_o ( data_qvalid_o                                              ),
    .ready_i ( data_qready_i                                              ),
    .data_o  ( {data_qaddr_o, data_qwrite_o, data_qdata_o, data_qstrb_o} )
  );

  // Memory response cut
  spill_register #(
    .Width  ( $bits(word_t)    ),
    .Bypass ( !RegisterMemResp )
  ) i_spill_register_mem_rsp (
    .clk_i   ( clk_i         ),
    .rst_i   ( rst_i         ),
    .valid_i ( data_pvalid_i ),
    .ready_o ( data_pready_o ),
    .data_i  ( data_pdata_i  ),
    .valid_o ( mem_pvalid    ),
    .ready_i ( mem_pready    ),
    .data_o  ( mem_pdata     )
  );

endmodule

//--- logic/offload_if.sv
`timescale 1ns/1ps

interface offload_req_if;
  import cc_pkg::*;

  acc_op_e  op;
  word_t    arga;
  word_t    argb;
  reg_idx_t id;
  logic     valid;
  logic     ready;

  modport issuer (output op, arga, argb, id, valid, input ready);
  modport server (input op, arga, argb, id, valid, output ready);
endinterface

interface offload_rsp_if;
  import cc_pkg::*;

  word_t    data;
  reg_idx_t id;
  logic     valid;
  logic     ready;

  modport issuer (output data, id, valid, input ready);
  modport server (input data, id, valid, output ready);
endinterface

//--- logic/rv32_int_core.sv
`timescale 1ns/1ps

module rv32_int_core (
  input  logic                 clk_i,
  input  logic                 rst_i,
  output cc_pkg::word_t        inst_addr_o,
  input  cc_pkg::word_t        inst_data_i,
  output logic                 inst_valid_o,
  input  logic                 inst_ready_i,
  offload_req_if.issuer        acc_req,
  offload_rsp_if.server        acc_rsp,
  output cc_pkg::word_t        data_qaddr_o,
  output logic                 data_qwrite_o,
  output cc_pkg::word_t        data_qdata_o,
  output cc_pkg::strb_t        data_qstrb_o,
  output logic                 data_qvalid_o,
  input  logic                 data_qready_i,
  input  cc_pkg::word_t        data_pdata_i,
  input  logic                 data_pvalid_i,
  output logic                 data_pready_o,
  output cc_pkg::core_events_t core_events_o
);

  import cc_pkg::*;

  core_state_e state_q, state_d;
  word_t       pc_q, ir_q;
  logic        ir_valid_q, fetch;

  logic [6:0]  opcode, funct7;
  logic [2:0]  funct3;
  reg_idx_t    rd, rs1, rs2;
  word_t       imm_i, imm_s;
  logic        is_alu, is_reg_op, is_sub, is_load, is_store, is_offload;
  logic        uses_rs2, writes_rd;

  word_t       gpr_q [1:31];
  word_t       opa, opb, alu_result;
  logic [31:0] busy_q, busy_d;
  logic        operands_ready, exec, retire;

  reg_idx_t    lsu_rd_q, wb_rd;
  word_t       wb_data;
  logic        alu_wb, load_wb, acc_wb;

  // --------------------------------------------------------------------------
  // Fetch and sequencing
  // --------------------------------------------------------------------------
  // Next fetch overlaps the retiring instruction, but never a load
  assign inst_valid_o = (state_q == RUN) && (!ir_valid_q || (retire && !is_load));
  assign inst_addr_o  = pc_q;
  assign fetch        = inst_valid_o && inst_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IDLE;
      pc_q       <= boot_addr;
      ir_valid_q <= 1'b0;
      busy_q     <= '0;
    end else begin
      state_q <= state_d;
      busy_q  <= busy_d;
      if (fetch) begin
        pc_q       <= pc_q + 32'd4;
        ir_valid_q <= 1'b1;
      end else if (retire) begin
        ir_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch) begin
      ir_q <= inst_data_i;
    end
    if (retire && is_load) begin
      lsu_rd_q <= rd;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: state_d = RUN;
      RUN: begin
        if (retire && is_load) begin
          state_d = WAIT_LOAD;
        end
      end
      WAIT_LOAD: begin
        if (load_wb) begin
          state_d = RUN;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // --------------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------------
  assign opcode = ir_q[6:0];
  assign rd     = ir_q[11:7];
  assign funct3 = ir_q[14:12];
  assign rs1    = ir_q[19:15];
  assign rs2    = ir_q[24:20];
  assign funct7 = ir_q[31:25];
  assign imm_i  = {{20{ir_q[31]}}, ir_q[31:20]};
  assign imm_s  = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};

  assign is_sub     = (funct7 == funct7_sub);
  assign is_reg_op  = (opcode == opcode_op) && (funct3 == funct3_add)
                      && ((funct7 == funct7_base) || is_sub);
  assign is_alu     = is_reg_op || ((opcode == opcode_op_imm) && (funct3 == funct3_add));
  assign is_load    = (opcode == opcode_load) && (funct3 == funct3_word);
  assign is_store   = (opcode == opcode_store) && (funct3 == funct3_word);
  assign is_offload = (opcode == opcode_op) && (funct7 == funct7_muldiv);
  assign uses_rs2   = is_reg_op || is_store || is_offload;
  assign writes_rd  = is_alu || is_load || is_offload;

  // --------------------------------------------------------------------------
  // Operands, scoreboard and issue
  // --------------------------------------------------------------------------
  assign opa = (rs1 == '0) ? '0 : gpr_q[rs1];
  assign opb = (rs2 == '0) ? '0 : gpr_q[rs2];

  assign operands_ready = !busy_q[rs1] && !(uses_rs2 && busy_q[rs2])
                          && !(writes_rd && busy_q[rd]);
  assign exec   = (state_q == RUN) && ir_valid_q && operands_ready;
  assign retire = exec && (!(is_load || is_store) || data_qready_i)
                  && (!is_offload || acc_req.ready);

  always_comb begin
    busy_d = busy_q;
    if (load_wb) begin
      busy_d[lsu_rd_q] = 1'b0;
    end
    if (acc_wb) begin
      busy_d[acc_rsp.id] = 1'b0;
    end
    if (retire && (is_load || is_offload)) begin
      busy_d[rd] = 1'b1;
    end
    busy_d[0] = 1'b0;
  end

  assign alu_result = is_reg_op ? (is_sub ? opa - opb : opa + opb) : opa + imm_i;

  // Load/store unit
  assign data_qvalid_o = exec && (is_load || is_store);
  assign data_qaddr_o  = opa + (is_store ? imm_s : imm_i);
  assign data_qwrite_o = is_store;
  assign data_qdata_o  = opb;
  assign data_qstrb_o  = is_store ? '1 : '0;
  assign data_pready_o = (state_q == WAIT_LOAD);

  // Offload issue, tagged with rd
  assign acc_req.valid = exec && is_offload;
  // funct3 bits 2:1 of MUL, MULHU, DIVU and REMU match the op encoding
  assign acc_req.op    = acc_op_e'(funct3[2:1]);
  assign acc_req.arga  = opa;
  assign acc_req.argb  = opb;
  assign acc_req.id    = rd;

  // --------------------------------------------------------------------------
  // Writeback, ALU before load before offload
  // --------------------------------------------------------------------------
  assign alu_wb        = exec && is_alu;
  assign load_wb       = data_pvalid_i && data_pready_o;
  assign acc_rsp.ready = !alu_wb && !load_wb;
  assign acc_wb        = acc_rsp.valid && acc_rsp.ready;

  always_comb begin
    wb_rd   = acc_rsp.id;
    wb_data = acc_rsp.data;
    if (alu_wb) begin
      wb_rd   = rd;
      wb_data = alu_result;
    end else if (load_wb) begin
      wb_rd   = lsu_rd_q;
      wb_data = data_pdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((alu_wb || load_wb || acc_wb) && (wb_rd != '0)) begin
      gpr_q[wb_rd] <= wb_data;
    end
  end

  assign core_events_o = {acc_wb, load_wb, retire};

endmodule

//--- logic/shared_muldiv.sv
`timescale 1ns/1ps

module shared_muldiv (
  input  logic          clk_i,
  input  logic          rst_i,
  offload_req_if.server req,
  offload_rsp_if.issuer rsp
);

  import cc_pkg::*;

  logic                   is_div, mul_accept, div_accept;
  logic                   mul_stall, mul_out_valid;
  logic [63:0]            product;
  word_t                  mul_res;
  logic [mul_latency-1:0] mul_valid_q;
  reg_idx_t               mul_id_q  [mul_latency];
  word_t                  mul_res_q [mul_latency];

  logic                   div_busy_q, div_rem_q, div_done, div_taken, div_ge;
  logic [5:0]             div_cnt_q;
  reg_idx_t               div_id_q;
  word_t                  div_divisor_q, div_acc_q, div_quo_q;
  logic [32:0]            div_shift;

  // --------------------------------------------------------------------------
  // Request steering
  // --------------------------------------------------------------------------
  assign is_div     = (req.op == DIVU) || (req.op == REMU);
  assign req.ready  = is_div ? !div_busy_q : !mul_stall;
  assign mul_accept = req.valid && req.ready && !is_div;
  assign div_accept = req.valid && req.ready && is_div;

  // --------------------------------------------------------------------------
  // Multiplier pipeline
  // --------------------------------------------------------------------------
  assign product       = 64'(req.arga) * 64'(req.argb);
  assign mul_res       = (req.op == MULHU) ? product[63:32] : product[31:0];
  assign mul_out_valid = mul_valid_q[mul_latency-1];
  // Whole pipe freezes while the last stage waits on rsp
  assign mul_stall     = mul_out_valid && !rsp.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mul_valid_q <= '0;
    end else if (!mul_stall) begin
      mul_valid_q <= {mul_valid_q[mul_latency-2:0], mul_accept};
    end
  end

  always_ff @(posedge clk_i) begin
    if (!mul_stall) begin
      mul_id_q[0]  <= req.id;
      mul_res_q[0] <= mul_res;
      for (int i = 1; i < mul_latency; i++) begin
        mul_id_q[i]  <= mul_id_q[i-1];
        mul_res_q[i] <= mul_res_q[i-1];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Shift-subtract divider, one quotient bit per cycle
  // --------------------------------------------------------------------------
  assign div_shift = {div_acc_q, div_quo_q[31]};
  // Zero divisor always subtracts, so quotient is all ones, remainder the dividend
  assign div_ge    = div_shift >= {1'b0, div_divisor_q};
  assign div_done  = div_busy_q && (div_cnt_q == '0);
  assign div_taken = div_done && !mul_out_valid && rsp.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      div_busy_q <= 1'b0;
      div_cnt_q  <= '0;
    end else if (div_accept) begin
      div_busy_q <= 1'b1;
      div_cnt_q  <= 6'd32;
    end else if (div_cnt_q != '0) begin
      div_cnt_q <= div_cnt_q - 6'd1;
    end else if (div_taken) begin
      div_busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_accept) begin
      div_acc_q     <= '0;
      div_quo_q     <= req.arga;
      div_divisor_q <= req.argb;
      div_id_q      <= req.id;
      div_rem_q     <= (req.op == REMU);
    end else if (div_cnt_q != '0) begin
      div_acc_q <= div_ge ? div_shift[31:0] - div_divisor_q : div_shift[31:0];
      div_quo_q <= {div_quo_q[30:0], div_ge};
    end
  end

  // --------------------------------------------------------------------------
  // Response arbiter, multiplier first
  // --------------------------------------------------------------------------
  assign rsp.valid = mul_out_valid || div_done;
  assign rsp.id    = mul_out_valid ? mul_id_q[mul_latency-1] : div_id_q;
  assign rsp.data  = mul_out_valid ? mul_res_q[mul_latency-1]
                   : (div_rem_q ? div_acc_q : div_quo_q);

endmodule

//--- logic/spill_register.sv
`timescale 1ns/1ps

module spill_register #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [Width-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [Width-1:0] data_o
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign ready_o = ready_i;
    assign data_o  = data_i;
  end else begin : gen_spill
    // Slot a takes new input, slot b catches it when the output stalls
    logic             a_full_q, b_full_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Both handshake sides see registered state only
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    // Older item sits in b whenever b is full
    assign data_o  = b_full_q ? b_data_q : a_data_q;
  end

endmodule

//--- tb/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// --------------------------------------------------------------------------
// Random program generator and in-order reference model
// --------------------------------------------------------------------------
typedef struct packed {
  logic        write;
  logic [31:0] addr;
  logic [31:0] data;
} mem_op_t;

localparam int unsigned num_random = 300;
// Register init prelude, random body, final register stores
localparam int unsigned num_insts  = 31 + num_random + 31;

logic [31:0] lfsr_q = 32'h950;
logic [31:0] program_mem [num_insts];
mem_op_t     expected_ops [$];
int unsigned expected_loads;
int unsigned expected_offloads;

// Taps 32, 22, 2, 1
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
  lfsr_q = {lfsr_q[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// Initial data memory contents, mixed from every address bit
function automatic logic [31:0] fill_word(input logic [31:0] addr);
  return (addr * 32'h9E37_79B9) ^ 32'h6A09_E667;
endfunction

function automatic logic [31:0] encode_rtype(input logic [6:0] f7, input logic [2:0] f3,
                                             input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] encode_itype(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encode_store(input logic [11:0] imm, input logic [4:0] rs2);
  return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
endfunction

task automatic build_program();
  int unsigned n;
  logic [3:0]  kind;
  logic [4:0]  rd, rs1, rs2;
  logic [5:0]  word;
  n = 0;
  for (int r = 1; r < 32; r++) begin
    program_mem[n] = encode_itype(12'(rand_bits(12)), 5'd0, 3'b000, 5'(r), 7'b0010011);
    n++;
  end
  for (int i = 0; i < num_random; i++) begin
    kind = 4'(rand_bits(4));
    rd   = 5'(rand_bits(5));
    rs1  = 5'(rand_bits(5));
    rs2  = 5'(rand_bits(5));
    // Memory accesses use x0 as base inside the 256-byte region
    case (kind)
      4'd0, 4'd1, 4'd2, 4'd3: begin
        program_mem[n] = encode_itype(12'(rand_bits(12)), rs1, 3'b000, rd, 7'b0010011);
      end
      4'd4, 4'd5: program_mem[n] = encode_rtype(7'b0000000, 3'b000, rd, rs1, rs2);
      4'd6, 4'd7: program_mem[n] = encode_rtype(7'b0100000, 3'b000, rd, rs1, rs2);
      4'd8, 4'd9: begin
        word = 6'(rand_bits(6));
        program_mem[n] = encode_itype({4'd0, word, 2'd0}, 5'd0, 3'b010, rd, 7'b0000011);
      end
      4'd10, 4'd11: begin
        word = 6'(rand_bits(6));
        program_mem[n] = encode_store({4'd0, word, 2'd0}, rs2);
      end
      4'd12: program_mem[n] = encode_rtype(7'b0000001, 3'b000, rd, rs1, rs2);
      4'd13: program_mem[n] = encode_rtype(7'b0000001, 3'b011, rd, rs1, rs2);
      default: begin
        // Divide by zero about one time in four
        if (rand_bits(2) == 0) begin
          rs2 = 5'd0;
        end
        program_mem[n] = encode_rtype(7'b0000001, {1'b1, kind[0], 1'b1}, rd, rs1, rs2);
      end
    endcase
    n++;
  end
  for (int r = 1; r < 32; r++) begin
    program_mem[n] = encode_store(12'(r * 4), 5'(r));
    n++;
  end
endtask

task automatic run_model();
  logic [31:0] regs [32];
  logic [31:0] mem [64];
  logic [31:0] ir, a, b, res, addr;
  logic [63:0] prod;
  logic        writes;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  for (int i = 0; i < 64; i++) begin
    mem[i] = fill_word(32'(i * 4));
  end
  expected_loads    = 0;
  expected_offloads = 0;
  for (int i = 0; i < num_insts; i++) begin
    ir     = program_mem[i];
    a      = regs[ir[19:15]];
    b      = regs[ir[24:20]];
    prod   = {32'd0, a} * {32'd0, b};
    res    = '0;
    writes = 1'b1;
    case (ir[6:0])
      7'b0010011: res = a + {{20{ir[31]}}, ir[31:20]};
      7'b0110011: begin
        if (ir[25]) begin
          expected_offloads++;
          case (ir[14:12])
            3'b000:  res = prod[31:0];
            3'b011:  res = prod[63:32];
            3'b101:  res = (b == 0) ? 32'hFFFF_FFFF : a / b;
            default: res = (b == 0) ? a : a % b;
          endcase
        end else begin
          res = ir[30] ? a - b : a + b;
        end
      end
      7'b0000011: begin
        addr = a + {{20{ir[31]}}, ir[31:20]};
        res  = mem[addr[7:2]];
        expected_loads++;
        expected_ops.push_back('{write: 1'b0, addr: addr, data: 32'd0});
      end
      default: begin
        addr = a + {{20{ir[31]}}, ir[31:25], ir[11:7]};
        mem[addr[7:2]] = b;
        writes = 1'b0;
        expected_ops.push_back('{write: 1'b1, addr: addr, data: b});
      end
    endcase
    if (writes && (ir[11:7] != 0)) begin
      regs[ir[11:7]] = res;
    end
  end
endtask

`endif

//--- tb/tb_core_complex.sv
`timescale 1ns/1ps

module tb_core_complex;

  localparam logic [31:0] first_pc       = 32'h0000_1000;
  localparam int unsigned timeout_cycles = 50000;

  logic        clk_i, rst_i;
  logic [31:0] inst_addr_o, inst_data_i;
  logic        inst_valid_o, inst_ready_i;
  logic [31:0] data_qaddr_o, data_qdata_o, data_pdata_i;
  logic [3:0]  data_qstrb_o;
  logic        data_qwrite_o, data_qvalid_o, data_qready_i;
  logic        data_pvalid_i, data_pready_o;
  logic [2:0]  core_events_o;

  `include "tb_iss.svh"

  logic [31:0] mem_q [64];
  int unsigned fetch_count, retired, loads_seen, offloads_seen;
  logic        load_pending;
  logic [2:0]  load_delay;
  logic [31:0] load_data;

  core_complex #(
    .RegisterOffloadReq  ( 1'b1 ),
    .RegisterOffloadResp ( 1'b1 ),
    .RegisterMemReq      ( 1'b0 ),
    .RegisterMemResp     ( 1'b0 )
  ) i_dut (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .inst_addr_o   ( inst_addr_o   ),
    .inst_data_i   ( inst_data_i   ),
    .inst_valid_o  ( inst_valid_o  ),
    .inst_ready_i  ( inst_ready_i  ),
    .data_qaddr_o  ( data_qaddr_o  ),
    .data_qwrite_o ( data_qwrite_o ),
    .data_qdata_o  ( data_qdata_o  ),
    .data_qstrb_o  ( data_qstrb_o  ),
    .data_qvalid_o ( data_qvalid_o ),
    .data_qready_i ( data_qready_i ),
    .data_pdata_i  ( data_pdata_i  ),
    .data_pvalid_i ( data_pvalid_i ),
    .data_pready_o ( data_pready_o ),
    .core_events_o ( core_events_o )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  task automatic stop_on_error();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_word(input string name, input logic [31:0] expected, actual);
    assert (actual === expected) else begin
      $display("MISMATCH t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      stop_on_error();
    end
  endtask

  task automatic check_idle_outputs();
    compare_word("inst_valid_o", 32'd0, 32'(inst_valid_o));
    compare_word("data_qvalid_o", 32'd0, 32'(data_qvalid_o));
    compare_word("core_events_o", 32'd0, 32'(core_events_o));
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic drive_inputs();
    int unsigned idx;
    idx          = (inst_addr_o - first_pc) >> 2;
    inst_ready_i = 1'b0;
    inst_data_i  = 32'd0;
    if (idx < num_insts) begin
      inst_data_i  = program_mem[idx];
      inst_ready_i = (rand_bits(2) != 0);
    end
    data_qready_i = (rand_bits(2) != 0);
    data_pvalid_i = 1'b0;
    if (load_pending) begin
      if (load_delay == 0) begin
        data_pvalid_i = 1'b1;
        data_pdata_i  = load_data;
      end else begin
        load_delay--;
      end
    end
  endtask

  // Sampled on the falling edge, where every handshake is settled
  task automatic sample_cycle();
    mem_op_t op;
    if (core_events_o[0]) retired++;
    if (core_events_o[1]) loads_seen++;
    if (core_events_o[2]) offloads_seen++;
    if (inst_valid_o && inst_ready_i) begin
      compare_word("inst_addr_o", first_pc + 32'(4 * fetch_count), inst_addr_o);
      fetch_count++;
    end
    if (data_pvalid_i && data_pready_o) begin
      load_pending = 1'b0;
    end
    if (data_qvalid_o && data_qready_i) begin
      assert ((expected_ops.size() > 0) && !load_pending) else begin
        $display("Unexpected memory request at t=%0t: program has none left or a load is open",
                 $time);
        stop_on_error();
      end
      op = expected_ops.pop_front();
      compare_word("data_qwrite_o", 32'(op.write), 32'(data_qwrite_o));
      compare_word("data_qaddr_o", op.addr, data_qaddr_o);
      if (op.write) begin
        compare_word("data_qdata_o", op.data, data_qdata_o);
        compare_word("data_qstrb_o", 32'hF, 32'(data_qstrb_o));
        mem_q[data_qaddr_o[7:2]] = data_qdata_o;
      end else begin
        load_data    = mem_q[data_qaddr_o[7:2]];
        load_delay   = 3'(rand_bits(3));
        load_pending = 1'b1;
      end
    end
  endtask

  initial begin
    int unsigned cycles;
    logic        done;
    rst_i         = 1'b1;
    inst_data_i   = 32'd0;
    inst_ready_i  = 1'b0;
    data_qready_i = 1'b0;
    data_pdata_i  = 32'd0;
    data_pvalid_i = 1'b0;
    fetch_count   = 0;
    retired       = 0;
    loads_seen    = 0;
    offloads_seen = 0;
    load_pending  = 1'b0;
    load_delay    = '0;
    load_data     = '0;
    build_program();
    run_model();
    for (int i = 0; i < 64; i++) begin
      mem_q[i] = fill_word(32'(i * 4));
    end

    // First reset edge
    @(posedge clk_i);
    @(negedge clk_i);
    check_idle_outputs();
    @(posedge clk_i);
    #1 rst_i = 1'b0;
    // Cycle in which reset ends
    @(negedge clk_i);
    check_idle_outputs();

    cycles = 0;
    done   = 1'b0;
    while (!done && (cycles < timeout_cycles)) begin
      @(posedge clk_i);
      #1;
      drive_inputs();
      @(negedge clk_i);
      sample_cycle();
      cycles++;
      done = (retired == num_insts) && (loads_seen == expected_loads)
             && (offloads_seen == expected_offloads) && (expected_ops.size() == 0);
    end

    if (!done) begin
      $display("Timeout: program not completed within %0d cycles", timeout_cycles);
      stop_on_error();
    end else begin
      // Idle tail, no further events may appear
      repeat (20) begin
        @(posedge clk_i);
        #1;
        drive_inputs();
        @(negedge clk_i);
        sample_cycle();
      end
      compare_word("core_events_o[0] count", num_insts, retired);
      compare_word("core_events_o[1] count", expected_loads, loads_seen);
      compare_word("core_events_o[2] count", expected_offloads, offloads_seen);
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+tb
logic/cc_pkg.sv
logic/offload_if.sv
logic/spill_register.sv
logic/shared_muldiv.sv
logic/rv32_int_core.sv
logic/core_complex.sv
tb/tb_core_complex.sv
